/* Bender.yml */
package:
  name: rv_decode

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_instr_decoder.sv
  - rv_imm_gen.sv
  - rv_regfile.sv
  - rv_decode_stage.sv
  - rv_decode_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - rv_decode_assert.sv
      - tb_rv_decode.sv

/* rv_decode_assert.sv */
`default_nettype none

module rv_decode_assert #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input logic [ADDR_WIDTH-1:0]   wb_adr,
    input logic                    out_valid,
    input logic                    out_ready,
    input logic [ADDR_WIDTH+133:0] out_payload  // Every out_ field, concatenated
);

    int unsigned fail_count = 0;

    a_stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
    else begin
        $error("wb_stb is high while wb_cyc is low");
        fail_count++;
    end

    // The address may only move once the slave has acked
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else begin
        $error("wb_adr or wb_stb changed before wb_ack");
        fail_count++;
    end

    a_out_held: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_payload)))
    else begin
        $error("Output changed while stalled by out_ready");
        fail_count++;
    end

endmodule

bind rv_decode_top rv_decode_assert #(
    .ADDR_WIDTH (ADDR_WIDTH)
) i_decode_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .wb_adr      (wb_adr),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_payload ({out_pc, out_format, out_opcode, out_funct3, out_funct7, out_rs1, out_rs2,
                   out_rd, out_rs1_en, out_rs2_en, out_rd_en, out_imm, out_rs1_data,
                   out_rs2_data})
);

`default_nettype wire

/* rv_decode_stage.sv */
`default_nettype none

module rv_decode_stage #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fetch_valid,
    input  logic [rv_pkg::xlen-1:0]        fetch_instr,
    input  logic [ADDR_WIDTH-1:0]          fetch_pc,
    output logic                           fetch_ready,
    input  logic                           rd_we,
    input  logic [rv_pkg::reg_index_w-1:0] rd_index,
    input  logic [rv_pkg::xlen-1:0]        rd_data,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [ADDR_WIDTH-1:0]          out_pc,
    output rv_pkg::instr_format_e          out_format,
    output logic [6:0]                     out_opcode,
    output logic [2:0]                     out_funct3,
    output logic [6:0]                     out_funct7,
    output logic [rv_pkg::reg_index_w-1:0] out_rs1,
    output logic [rv_pkg::reg_index_w-1:0] out_rs2,
    output logic [rv_pkg::reg_index_w-1:0] out_rd,
    output logic                           out_rs1_en,
    output logic                           out_rs2_en,
    output logic                           out_rd_en,
    output logic [rv_pkg::xlen-1:0]        out_imm,
    output logic [rv_pkg::xlen-1:0]        out_rs1_data,
    output logic [rv_pkg::xlen-1:0]        out_rs2_data
);
    import rv_pkg::*;

    instr_format_e          dec_format;
    logic [6:0]             dec_opcode;
    logic [2:0]             dec_funct3;
    logic [6:0]             dec_funct7;
    logic [reg_index_w-1:0] dec_rs1;
    logic [reg_index_w-1:0] dec_rs2;
    logic [reg_index_w-1:0] dec_rd;
    logic                   dec_rs1_en;
    logic                   dec_rs2_en;
    logic                   dec_rd_en;
    logic [xlen-1:0]        dec_imm;
    logic [xlen-1:0]        rs1_data;
    logic [xlen-1:0]        rs2_data;
    logic                   load;

    rv_instr_decoder i_decoder (
        .instr  (fetch_instr),
        .format (dec_format),
        .opcode (dec_opcode),
        .funct3 (dec_funct3),
        .funct7 (dec_funct7),
        .rs1    (dec_rs1),
        .rs2    (dec_rs2),
        .rd     (dec_rd),
        .rs1_en (dec_rs1_en),
        .rs2_en (dec_rs2_en),
        .rd_en  (dec_rd_en)
    );

    rv_imm_gen i_imm_gen (
        .instr  (fetch_instr),
        .format (dec_format),
        .imm    (dec_imm)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .wr_index (rd_index),
        .wr_data  (rd_data)
    );

    assign fetch_ready = !out_valid || out_ready;  // Output register empty or draining
    assign load        = fetch_valid && fetch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Fields only change on a load, which keeps them still under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc       <= fetch_pc;
            out_format   <= dec_format;
            out_opcode   <= dec_opcode;
            out_funct3   <= dec_funct3;
            out_funct7   <= dec_funct7;
            out_rs1      <= dec_rs1;
            out_rs2      <= dec_rs2;
            out_rd       <= dec_rd;
            out_rs1_en   <= dec_rs1_en;
            out_rs2_en   <= dec_rs2_en;
            out_rd_en    <= dec_rd_en;
            out_imm      <= dec_imm;
            out_rs1_data <= dec_rs1_en ? rs1_data : '0;  // Unused operands read as zero
            out_rs2_data <= dec_rs2_en ? rs2_data : '0;
        end
    end

endmodule

`default_nettype wire

/* rv_decode_top.sv */
`default_nettype none

module rv_decode_top #(
    parameter int unsigned           ADDR_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [ADDR_WIDTH-1:0]          wb_adr,
    input  logic [rv_pkg::xlen-1:0]        wb_rdata,
    input  logic                           wb_ack,
    input  logic                           rd_we,
    input  logic [rv_pkg::reg_index_w-1:0] rd_index,
    input  logic [rv_pkg::xlen-1:0]        rd_data,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [ADDR_WIDTH-1:0]          out_pc,
    output rv_pkg::instr_format_e          out_format,
    output logic [6:0]                     out_opcode,
    output logic [2:0]                     out_funct3,
    output logic [6:0]                     out_funct7,
    output logic [rv_pkg::reg_index_w-1:0] out_rs1,
    output logic [rv_pkg::reg_index_w-1:0] out_rs2,
    output logic [rv_pkg::reg_index_w-1:0] out_rd,
    output logic                           out_rs1_en,
    output logic                           out_rs2_en,
    output logic                           out_rd_en,
    output logic [rv_pkg::xlen-1:0]        out_imm,
    output logic [rv_pkg::xlen-1:0]        out_rs1_data,
    output logic [rv_pkg::xlen-1:0]        out_rs2_data
);
    import rv_pkg::*;

    logic                  fetch_valid;
    logic                  fetch_ready;
    logic [xlen-1:0]       fetch_instr;
    logic [ADDR_WIDTH-1:0] fetch_pc;

    rv_fetch #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready)
    );

    // Up to two instructions in flight, one in the fetch buffer and one here
    rv_decode_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_decode_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .fetch_ready  (fetch_ready),
        .rd_we        (rd_we),
        .rd_index     (rd_index),
        .rd_data      (rd_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_format   (out_format),
        .out_opcode   (out_opcode),
        .out_funct3   (out_funct3),
        .out_funct7   (out_funct7),
        .out_rs1      (out_rs1),
        .out_rs2      (out_rs2),
        .out_rd       (out_rd),
        .out_rs1_en   (out_rs1_en),
        .out_rs2_en   (out_rs2_en),
        .out_rd_en    (out_rd_en),
        .out_imm      (out_imm),
        .out_rs1_data (out_rs1_data),
        .out_rs2_data (out_rs2_data)
    );

endmodule

`default_nettype wire

/* rv_fetch.sv */
`default_nettype none

module rv_fetch #(
    parameter int unsigned           ADDR_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic [ADDR_WIDTH-1:0]   wb_adr,
    input  logic [rv_pkg::xlen-1:0] wb_rdata,
    input  logic                    wb_ack,
    output logic                    fetch_valid,
    output logic [rv_pkg::xlen-1:0] fetch_instr,
    output logic [ADDR_WIDTH-1:0]   fetch_pc,
    input  logic                    fetch_ready
);
    import rv_pkg::*;

    logic [ADDR_WIDTH-1:0] pc;
    logic                  req_active;  // One Wishbone read outstanding
    logic                  buf_valid;
    logic [xlen-1:0]       buf_instr;
    logic [ADDR_WIDTH-1:0] buf_pc;
    logic                  rd_done;

    assign rd_done = req_active && wb_ack;

    // A request only starts when the buffer will be empty after this edge, so the
    // buffer is always free by the time the ack arrives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            req_active <= 1'b0;
            buf_valid  <= 1'b0;
        end else begin
            if (req_active) begin
                if (wb_ack) begin
                    req_active <= 1'b0;  // Strobes drop for one cycle after each ack
                    pc         <= pc + ADDR_WIDTH'(4);
                end
            end else if (!buf_valid || fetch_ready) begin
                req_active <= 1'b1;
            end

            if (rd_done) begin
                buf_valid <= 1'b1;
            end else if (fetch_ready) begin
                buf_valid <= 1'b0;   // Drained by the decode stage
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done) begin
            buf_instr <= wb_rdata;
            buf_pc    <= pc;
        end
    end

    assign wb_cyc      = req_active;
    assign wb_stb      = req_active;
    assign wb_adr      = pc;  // Held until the ack edge
    assign fetch_valid = buf_valid;
    assign fetch_instr = buf_instr;
    assign fetch_pc    = buf_pc;

endmodule

`default_nettype wire

/* rv_imm_gen.sv */
`default_nettype none

module rv_imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::instr_format_e   format,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];  // Every format takes its sign from bit 31

    always_comb begin
        case (format)
            fmt_i: imm = {{(xlen-12){sign}}, instr[31:20]};
            fmt_s: imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            fmt_b: begin
                // Branch offsets are in halfwords, bit 0 is implied zero
                imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            fmt_u: imm = {instr[31:12], 12'b0};
            fmt_j: begin
                imm = {{(xlen-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;  // R format has no immediate
        endcase
    end

endmodule

`default_nettype wire

/* rv_instr_decoder.sv */
`default_nettype none

module rv_instr_decoder (
    input  logic [rv_pkg::xlen-1:0]        instr,
    output rv_pkg::instr_format_e          format,
    output logic [6:0]                     opcode,
    output logic [2:0]                     funct3,
    output logic [6:0]                     funct7,
    output logic [rv_pkg::reg_index_w-1:0] rs1,
    output logic [rv_pkg::reg_index_w-1:0] rs2,
    output logic [rv_pkg::reg_index_w-1:0] rd,
    output logic                           rs1_en,
    output logic                           rs2_en,
    output logic                           rd_en
);
    import rv_pkg::*;

    // Bits 1 to 0 are not looked at, so compressed encodings alias onto these
    always_comb begin
        case (instr[6:2])
            op_load, op_load_fp, op_op_imm, op_op_imm_32, op_jalr: format = fmt_i;
            op_branch:                                            format = fmt_b;
            op_store, op_store_fp:                                format = fmt_s;
            op_auipc, op_lui:                                     format = fmt_u;
            op_jal:                                               format = fmt_j;
            op_op, op_op_fp:                                      format = fmt_r;
            default:                                              format = fmt_none;
        endcase
    end

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        rs1_en = 1'b0;
        rs2_en = 1'b0;
        rd_en  = 1'b0;  // Illegal opcodes keep everything off
        case (format)
            fmt_i: begin
                rs1_en = 1'b1;
                rd_en  = 1'b1;
            end
            fmt_b, fmt_s: begin
                rs1_en = 1'b1;
                rs2_en = 1'b1;
            end
            fmt_u, fmt_j: begin
                rd_en = 1'b1;
            end
            fmt_r: begin
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                rd_en  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int unsigned xlen        = 32;  // Data and instruction word width
    localparam int unsigned reg_index_w = 5;

    // Encoding follows the instruction-type numbering used by the decoder
    typedef enum logic [2:0] {
        fmt_i    = 3'd0,
        fmt_b    = 3'd1,
        fmt_s    = 3'd2,
        fmt_u    = 3'd3,
        fmt_j    = 3'd4,
        fmt_r    = 3'd5,
        fmt_none = 3'd7   // Opcode matches no known format
    } instr_format_e;

    // Major opcodes, instruction bits 6 to 2
    localparam logic [4:0] op_load      = 5'b00000;
    localparam logic [4:0] op_load_fp   = 5'b00001;
    localparam logic [4:0] op_op_imm    = 5'b00100;
    localparam logic [4:0] op_auipc     = 5'b00101;
    localparam logic [4:0] op_op_imm_32 = 5'b00110;
    localparam logic [4:0] op_store     = 5'b01000;
    localparam logic [4:0] op_store_fp  = 5'b01001;
    localparam logic [4:0] op_op        = 5'b01100;
    localparam logic [4:0] op_lui       = 5'b01101;
    localparam logic [4:0] op_op_fp     = 5'b10100;
    localparam logic [4:0] op_branch    = 5'b11000;
    localparam logic [4:0] op_jalr      = 5'b11001;
    localparam logic [4:0] op_jal       = 5'b11011;

endpackage

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none

module rv_regfile (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [rv_pkg::reg_index_w-1:0] rs1,
    input  logic [rv_pkg::reg_index_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]        rs1_data,
    output logic [rv_pkg::xlen-1:0]        rs2_data,
    input  logic                           we,
    input  logic [rv_pkg::reg_index_w-1:0] wr_index,
    input  logic [rv_pkg::xlen-1:0]        wr_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];  // No storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_index != '0)) begin
            regs[wr_index] <= wr_data;
        end
    end

    // No write-through, a write shows up from the next cycle on
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* tb.f */
rv_pkg.sv
rv_fetch.sv
rv_instr_decoder.sv
rv_imm_gen.sv
rv_regfile.sv
rv_decode_stage.sv
rv_decode_top.sv
tb_clk_gen.sv
rv_decode_assert.sv
tb_rv_decode.sv

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned PERIOD       = 8,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset lets go just after an edge, like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_rv_decode.sv */
`default_nettype none

module tb_rv_decode;
    import rv_pkg::*;

    localparam int unsigned           ADDR_WIDTH = 32;
    localparam logic [ADDR_WIDTH-1:0] RESET_PC   = '0;
    localparam int unsigned           PERIOD     = 8;
    localparam int unsigned           NUM_INSTR  = 300;
    localparam int unsigned           MEM_WORDS  = 512;
    localparam time                   SETUP_TIME = 64 * PERIOD;  // Reset plus register loading
    localparam time                   TIMEOUT    = NUM_INSTR * 8 * PERIOD + SETUP_TIME;
    localparam logic [31:0]           LFSR_TAPS  = 32'h8020_0003;

    // Every package opcode, then three that match no format
    localparam logic [4:0] OPCODE_TABLE [16] = '{
        op_load, op_load_fp, op_op_imm, op_op_imm_32, op_jalr, op_branch, op_op, op_op_fp,
        op_store, op_store_fp, op_auipc, op_lui, op_jal,
        5'b00011, 5'b11100, 5'b11111
    };

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic [ADDR_WIDTH-1:0]  wb_adr;
    logic [xlen-1:0]        wb_rdata;
    logic                   wb_ack;
    logic                   rd_we;
    logic [reg_index_w-1:0] rd_index;
    logic [xlen-1:0]        rd_data;
    logic                   out_valid;
    logic                   out_ready;
    logic [ADDR_WIDTH-1:0]  out_pc;
    instr_format_e          out_format;
    logic [6:0]             out_opcode;
    logic [2:0]             out_funct3;
    logic [6:0]             out_funct7;
    logic [reg_index_w-1:0] out_rs1;
    logic [reg_index_w-1:0] out_rs2;
    logic [reg_index_w-1:0] out_rd;
    logic                   out_rs1_en;
    logic                   out_rs2_en;
    logic                   out_rd_en;
    logic [xlen-1:0]        out_imm;
    logic [xlen-1:0]        out_rs1_data;
    logic [xlen-1:0]        out_rs2_data;

    logic [31:0]           lfsr_state = 32'd40;
    logic [31:0]           mem [MEM_WORDS];
    logic [31:0]           reg_model [32];
    logic                  mem_open      = 1'b0;  // Low during phase one, ack withheld
    int                    wait_left     = -1;
    int unsigned           error_count   = 0;
    int unsigned           checked_count = 0;
    logic [ADDR_WIDTH-1:0] exp_pc        = RESET_PC;

    tb_clk_gen #(
        .PERIOD       (PERIOD),
        .RESET_CYCLES (2)
    ) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_decode_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .rd_we        (rd_we),
        .rd_index     (rd_index),
        .rd_data      (rd_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_format   (out_format),
        .out_opcode   (out_opcode),
        .out_funct3   (out_funct3),
        .out_funct7   (out_funct7),
        .out_rs1      (out_rs1),
        .out_rs2      (out_rs2),
        .out_rd       (out_rd),
        .out_rs1_en   (out_rs1_en),
        .out_rs2_en   (out_rs2_en),
        .out_rd_en    (out_rd_en),
        .out_imm      (out_imm),
        .out_rs1_data (out_rs1_data),
        .out_rs2_data (out_rs2_data)
    );

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic instr_format_e expected_format(input logic [31:0] word);
        logic [4:0] major;
        major = word[6:2];
        if (major inside {op_load, op_load_fp, op_op_imm, op_op_imm_32, op_jalr}) return fmt_i;
        if (major == op_branch) return fmt_b;
        if (major inside {op_store, op_store_fp}) return fmt_s;
        if (major inside {op_auipc, op_lui}) return fmt_u;
        if (major == op_jal) return fmt_j;
        if (major inside {op_op, op_op_fp}) return fmt_r;
        return fmt_none;
    endfunction

    // Bit order is rs1, rs2, rd
    function automatic logic [2:0] enables_for(input instr_format_e fmt);
        case (fmt)
            fmt_i:        return 3'b101;
            fmt_b, fmt_s: return 3'b110;
            fmt_u, fmt_j: return 3'b001;
            fmt_r:        return 3'b111;
            default:      return 3'b000;
        endcase
    endfunction

    // Immediate bits are packed at the top of the word, then shifted down arithmetically
    function automatic logic [31:0] build_imm(input logic [31:0] w, input instr_format_e fmt);
        logic [31:0] imm;
        case (fmt)
            fmt_i:   imm = $signed(w) >>> 20;
            fmt_s:   imm = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
            fmt_b:   imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}) >>> 19;
            fmt_u:   imm = {w[31:12], 12'b0};
            fmt_j:   imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}) >>> 11;
            default: imm = '0;
        endcase
        return imm;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_transfer();
        logic [31:0]   word;
        instr_format_e fmt;
        logic [2:0]    en;
        logic [31:0]   exp_rs1;
        logic [31:0]   exp_rs2;
        word    = mem[exp_pc[10:2]];
        fmt     = expected_format(word);
        en      = enables_for(fmt);
        exp_rs1 = en[2] ? reg_model[word[19:15]] : '0;
        exp_rs2 = en[1] ? reg_model[word[24:20]] : '0;
        compare_field("out_pc", 32'(out_pc), 32'(exp_pc));
        compare_field("out_format", 32'(out_format), 32'(fmt));
        compare_field("out_opcode", 32'(out_opcode), 32'(word[6:0]));
        compare_field("out_funct3", 32'(out_funct3), 32'(word[14:12]));
        compare_field("out_funct7", 32'(out_funct7), 32'(word[31:25]));
        compare_field("out_rs1", 32'(out_rs1), 32'(word[19:15]));
        compare_field("out_rs2", 32'(out_rs2), 32'(word[24:20]));
        compare_field("out_rd", 32'(out_rd), 32'(word[11:7]));
        compare_field("out_rs1_en", 32'(out_rs1_en), 32'(en[2]));
        compare_field("out_rs2_en", 32'(out_rs2_en), 32'(en[1]));
        compare_field("out_rd_en", 32'(out_rd_en), 32'(en[0]));
        compare_field("out_imm", out_imm, build_imm(word, fmt));
        compare_field("out_rs1_data", out_rs1_data, exp_rs1);
        compare_field("out_rs2_data", out_rs2_data, exp_rs2);
        exp_pc = exp_pc + ADDR_WIDTH'(4);
        checked_count++;
    endtask

    task automatic finish_run();
        int unsigned assert_errors;
        assert_errors = i_dut.i_decode_assert.fail_count;
        $display("Transfers checked: %0d, compare errors: %0d, assertion errors: %0d",
                 checked_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] pick;
        wb_rdata  = '0;
        wb_ack    = 1'b0;
        rd_we     = 1'b0;
        rd_index  = '0;
        rd_data   = '0;
        out_ready = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            word   = rand_bits(32);
            pick   = rand_bits(4);
            mem[a] = {word[31:7], OPCODE_TABLE[pick[3:0]], 2'b11};
        end
        @(posedge rst_n);
        compare_field("out_valid", 32'(out_valid), 32'd0);
        compare_field("wb_cyc", 32'(wb_cyc), 32'd0);
        // Phase one loads every register, x0 gets a value that must be dropped
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #1;
            rd_we        = 1'b1;
            rd_index     = 5'(i);
            rd_data      = (i == 0) ? 32'hffff_ffff : rand_bits(32);
            reg_model[i] = (i == 0) ? '0 : rd_data;
        end
        @(posedge clk);
        #1;
        rd_we = 1'b0;
        @(negedge clk);
        mem_open = 1'b1;
        wait (checked_count == NUM_INSTR);
        repeat (4) @(posedge clk);
        finish_run();
    end

    // Memory model and out_ready, both driven just after the edge from one LFSR
    always begin
        logic [31:0] ready_bits;
        @(posedge clk);
        #1;
        if (mem_open) begin
            ready_bits = rand_bits(2);
            out_ready  = (ready_bits != 0);
            if (wb_ack) begin
                wb_ack = 1'b0;  // Taken at the edge just gone
            end else if (wb_stb) begin
                if (wait_left < 0) begin
                    wait_left = int'(rand_bits(2));
                end
                if (wait_left == 0) begin
                    wb_ack    = 1'b1;
                    wb_rdata  = mem[wb_adr[10:2]];
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // Handshake is settled by the falling edge, the transfer lands at the next rising one
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready && checked_count < NUM_INSTR) begin
            check_transfer();
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: only %0d of %0d instructions came out in time",
                 checked_count, NUM_INSTR);
        error_count++;
        finish_run();
    end

endmodule

`default_nettype wire
